//--- cache_cfg.svh
// Cache geometry macros, included by the package and by every RTL file that sizes logic.
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Width of the byte address minus its two low bits.
`define CACHE_WADDR_W 14

// Words per line.
`define CACHE_LINE_WORDS 4

// Sets per way.
`define CACHE_SETS 8

// Number of ways.
`define CACHE_WAYS 2

// Derived field widths of a word address.
`define CACHE_OFFSET_W $clog2(`CACHE_LINE_WORDS)
`define CACHE_INDEX_W $clog2(`CACHE_SETS)
`define CACHE_TAG_W (`CACHE_WADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

//--- cache_pkg.sv
// Shared cache types, imported by wildcard into each RTL module header.
`default_nettype none
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CACHE_WADDR_W-1:0] waddr_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    // One way of a set.
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // All ways of a set plus the round-robin victim pointer.
    typedef struct packed {
        way_t                         next_way;
        tag_entry_t [`CACHE_WAYS-1:0] entry;
    } tag_set_t;

    // One word of every way, stored per set and offset.
    typedef word_t [`CACHE_WAYS-1:0] data_row_t;

endpackage

`default_nettype wire

//--- sdp_ram.sv
// Simple dual-port synchronous RAM; instantiated for the tag sets and the data rows.
`timescale 1ns/1ns
`default_nettype none

module sdp_ram import cache_pkg::*; #(
    parameter type payload_t = word_t,
    parameter int  DEPTH     = 8,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  payload_t      wdata,
    input  logic [AW-1:0] raddr,
    output payload_t      rdata
);

    payload_t mem [DEPTH];

    // Read during write to the same address returns the old contents.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- tag_store.sv
// Tag RAM with hit decode, victim report and set update; used by the cache top level.
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module tag_store import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  index_t rd_index,
    input  tag_t   lookup_tag,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag,
    input  logic   mark_dirty,
    input  logic   fill_done,
    input  index_t wr_index,
    output logic   clearing_busy
);

    tag_set_t ram_rdata;
    tag_set_t fwd_set;
    logic     fwd_hit;
    tag_set_t set_q;
    tag_set_t new_set;
    logic     tag_we;
    index_t   tag_waddr;
    tag_set_t tag_wdata;
    index_t   clr_index;

    sdp_ram #(
        .payload_t (tag_set_t),
        .DEPTH     (`CACHE_SETS)
    ) u_tag_ram (
        .clk   (clk),
        .we    (tag_we),
        .waddr (tag_waddr),
        .wdata (tag_wdata),
        .raddr (rd_index),
        .rdata (ram_rdata)
    );

    // Sweep every set to zero after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clearing_busy <= 1'b1;
            clr_index     <= '0;
        end else if (clearing_busy) begin
            clr_index <= clr_index + 1'b1;
            if (clr_index == index_t'(`CACHE_SETS - 1)) begin
                clearing_busy <= 1'b0;
            end
        end
    end

    // A set written on the edge it was read comes from here instead.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_hit <= 1'b0;
        end else begin
            fwd_hit <= tag_we && (tag_waddr == rd_index);
        end
    end

    always_ff @(posedge clk) begin
        fwd_set <= tag_wdata;
    end

    assign set_q = fwd_hit ? fwd_set : ram_rdata;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (set_q.entry[w].valid && (set_q.entry[w].tag == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign victim_way   = set_q.next_way;
    assign victim_dirty = set_q.entry[victim_way].valid && set_q.entry[victim_way].dirty;
    assign victim_tag   = set_q.entry[victim_way].tag;

    // A fill claims the victim way and moves the pointer on.
    always_comb begin
        new_set = set_q;
        if (fill_done) begin
            new_set.entry[victim_way].valid = 1'b1;
            new_set.entry[victim_way].dirty = 1'b0;
            new_set.entry[victim_way].tag   = lookup_tag;
            new_set.next_way                = victim_way + 1'b1;
        end else if (mark_dirty) begin
            new_set.entry[hit_way].dirty = 1'b1;
        end
    end

    assign tag_we    = clearing_busy || mark_dirty || fill_done;
    assign tag_waddr = clearing_busy ? clr_index : wr_index;
    assign tag_wdata = clearing_busy ? '0 : new_set;

    // Write hits and fill completions come from separate blocks and must not meet.
    assert property (@(posedge clk) disable iff (!rst_n) !(mark_dirty && fill_done))
        else $error("tag_store: write hit during fill completion");

endmodule

`default_nettype wire

//--- line_engine.sv
// Line sequencer for the cache, writing back dirty victims and filling lines from memory.
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module line_engine import cache_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      miss_start,
    input  index_t                                    miss_index,
    input  tag_t                                      new_tag,
    input  way_t                                      victim_way,
    input  logic                                      victim_dirty,
    input  tag_t                                      victim_tag,
    output logic                                      fill_done,
    output logic                                      busy,
    output logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] dram_raddr,
    input  data_row_t                                 dram_rdata,
    output logic                                      dram_we,
    output way_t                                      dram_way,
    output logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] dram_waddr,
    output word_t                                     dram_wdata,
    output logic                                      xm_re,
    output logic                                      xm_we,
    output waddr_t                                    xm_addr,
    output word_t                                     xm_wdata,
    input  word_t                                     xm_rdata,
    input  logic                                      xm_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_FILL
    } state_t;

    state_t  state;
    offset_t offset;
    offset_t off_next;
    logic    step;
    logic    last;
    index_t  line_index;
    tag_t    wb_tag;
    tag_t    fill_tag;
    way_t    way_q;

    assign busy     = state != ST_IDLE;
    assign step     = busy && xm_ready;
    assign off_next = offset + 1'b1;
    assign last     = offset == offset_t'(`CACHE_LINE_WORDS - 1);

    // Offset wraps back to zero at the end of each pass.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            offset    <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (miss_start) begin
                        state <= victim_dirty ? ST_WB : ST_FILL;
                    end
                end
                ST_WB: begin
                    if (xm_ready) begin
                        offset <= off_next;
                        if (last) begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_FILL: begin
                    if (xm_ready) begin
                        offset <= off_next;
                        if (last) begin
                            state     <= ST_IDLE;
                            fill_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Miss context is held for the whole sequence.
    always_ff @(posedge clk) begin
        if (miss_start && !busy) begin
            line_index <= miss_index;
            wb_tag     <= victim_tag;
            fill_tag   <= new_tag;
            way_q      <= victim_way;
        end
    end

    // Row for the current offset is always one read ahead.
    // In idle the offset rests at zero, so the first row is ready on entry.
    assign dram_raddr = busy ? {line_index, step ? off_next : offset} : {miss_index, offset};

    assign dram_we    = (state == ST_FILL) && xm_ready;
    assign dram_way   = way_q;
    assign dram_waddr = {line_index, offset};
    assign dram_wdata = xm_rdata;

    assign xm_re    = state == ST_FILL;
    assign xm_we    = state == ST_WB;
    assign xm_addr  = {(state == ST_WB) ? wb_tag : fill_tag, line_index, offset};
    assign xm_wdata = dram_rdata[way_q];

    assert property (@(posedge clk) disable iff (!rst_n) !(xm_re && xm_we))
        else $error("line_engine: read and write requested together");

    // A stalled request keeps its address, and a write keeps its data word.
    assert property (@(posedge clk) disable iff (!rst_n)
        (xm_re || xm_we) && !xm_ready |=>
            $stable(xm_addr) && (!xm_we || $stable(xm_wdata)))
        else $error("line_engine: request changed while waiting");

endmodule

`default_nettype wire

//--- cache_top.sv
// Cache top level between the processor word bus and external memory; the DUT of the testbench.
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module cache_top import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   re,
    input  logic   we,
    input  waddr_t addr,
    input  word_t  wdata,
    output word_t  rdata,
    output logic   ready,
    output logic   xm_re,
    output logic   xm_we,
    output waddr_t xm_addr,
    output word_t  xm_wdata,
    input  word_t  xm_rdata,
    input  logic   xm_ready
);

    localparam int ROW_AW = `CACHE_INDEX_W + `CACHE_OFFSET_W;

    logic              pending;
    logic              wait_fill;
    logic              ab_we;
    waddr_t            ab_addr;
    word_t             ab_wdata;
    tag_t              ab_tag;
    index_t            ab_index;
    offset_t           ab_offset;
    index_t            in_index;
    offset_t           in_offset;
    logic              hit;
    way_t              hit_way;
    way_t              victim_way;
    logic              victim_dirty;
    tag_t              victim_tag;
    logic              clearing_busy;
    logic              mark_dirty;
    logic              miss_start;
    logic              fill_done;
    logic              le_busy;
    logic [ROW_AW-1:0] le_raddr;
    logic              le_we;
    way_t              le_way;
    logic [ROW_AW-1:0] le_waddr;
    word_t             le_wdata;
    logic [ROW_AW-1:0] dram_raddr;
    logic              dram_we;
    logic [ROW_AW-1:0] dram_waddr;
    data_row_t         dram_wdata;
    data_row_t         dram_rdata;
    logic              fwd_hit;
    data_row_t         fwd_row;
    data_row_t         row_q;
    way_t              wr_way;
    word_t             wr_word;

    assign {ab_tag, ab_index, ab_offset} = ab_addr;
    assign in_index  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign in_offset = addr[`CACHE_OFFSET_W-1:0];

    // Lookup result of the buffered access is valid while pending.
    assign miss_start = pending && !hit;
    assign mark_dirty = pending && hit && ab_we;
    assign ready      = !clearing_busy && !wait_fill && !miss_start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            wait_fill <= 1'b0;
        end else if (miss_start) begin
            pending   <= 1'b0;
            wait_fill <= 1'b1;
        end else if (fill_done) begin
            // Replay the lookup, which now hits.
            pending   <= 1'b1;
            wait_fill <= 1'b0;
        end else if (ready) begin
            pending <= re || we;
        end
    end

    // Access buffer.
    always_ff @(posedge clk) begin
        if (ready && (re || we)) begin
            ab_we    <= we;
            ab_addr  <= addr;
            ab_wdata <= wdata;
        end
    end

    tag_store u_tags (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_index      (ready ? in_index : ab_index),
        .lookup_tag    (ab_tag),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .mark_dirty    (mark_dirty),
        .fill_done     (fill_done),
        .wr_index      (ab_index),
        .clearing_busy (clearing_busy)
    );

    line_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .miss_start   (miss_start),
        .miss_index   (ab_index),
        .new_tag      (ab_tag),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .fill_done    (fill_done),
        .busy         (le_busy),
        .dram_raddr   (le_raddr),
        .dram_rdata   (row_q),
        .dram_we      (le_we),
        .dram_way     (le_way),
        .dram_waddr   (le_waddr),
        .dram_wdata   (le_wdata),
        .xm_re        (xm_re),
        .xm_we        (xm_we),
        .xm_addr      (xm_addr),
        .xm_wdata     (xm_wdata),
        .xm_rdata     (xm_rdata),
        .xm_ready     (xm_ready)
    );

    sdp_ram #(
        .payload_t (data_row_t),
        .DEPTH     (`CACHE_SETS * `CACHE_LINE_WORDS)
    ) u_data_ram (
        .clk   (clk),
        .we    (dram_we),
        .waddr (dram_waddr),
        .wdata (dram_wdata),
        .raddr (dram_raddr),
        .rdata (dram_rdata)
    );

    // Engine owns the read port from the miss cycle on.
    assign dram_raddr = (le_busy || miss_start) ? le_raddr :
                        ready ? {in_index, in_offset} : {ab_index, ab_offset};

    // Both writers replace one word of the row that was just read.
    assign dram_we    = le_we || mark_dirty;
    assign dram_waddr = le_we ? le_waddr : {ab_index, ab_offset};
    assign wr_way     = le_we ? le_way : hit_way;
    assign wr_word    = le_we ? le_wdata : ab_wdata;

    always_comb begin
        dram_wdata         = row_q;
        dram_wdata[wr_way] = wr_word;
    end

    // Row written on the same edge as its read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_hit <= 1'b0;
        end else begin
            fwd_hit <= dram_we && (dram_waddr == dram_raddr);
        end
    end

    always_ff @(posedge clk) begin
        fwd_row <= dram_wdata;
    end

    assign row_q = fwd_hit ? fwd_row : dram_rdata;
    assign rdata = row_q[hit_way];

    assert property (@(posedge clk) disable iff (!rst_n) le_busy |-> !ready)
        else $error("cache_top: ready raised during a line transfer");

endmodule

`default_nettype wire

//--- ext_mem_model.sv
// External word memory for the cache testbench, with zero to three random wait cycles per request.
`timescale 1ns/1ns
`default_nettype none

module ext_mem_model import cache_pkg::*; #(
    parameter logic [31:0] SEED  = 32'h1,
    parameter int          DEPTH = 1 << $bits(waddr_t)
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   xm_re,
    input  logic   xm_we,
    input  waddr_t xm_addr,
    input  word_t  xm_wdata,
    output word_t  xm_rdata,
    output logic   xm_ready
);

    word_t       mem [DEPTH];
    logic [31:0] rng;
    logic [1:0]  wait_left;

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Contents depend on the seed and the full word address.
    function automatic word_t initial_word(input int i);
        return lcg_step(SEED ^ 32'(i));
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = initial_word(i);
        end
    end

    assign xm_ready = (xm_re || xm_we) && (wait_left == 2'd0);
    assign xm_rdata = mem[xm_addr];

    // Wait count for the next request is drawn when the current one completes.
    always @(posedge clk) begin
        if (!rst_n) begin
            rng       <= ~SEED;
            wait_left <= 2'd0;
        end else if (xm_re || xm_we) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                if (xm_we) begin
                    mem[xm_addr] <= xm_wdata;
                end
                rng       <= lcg_step(rng);
                wait_left <= rng[31:30];
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_cache.sv
// Testbench top for the cache; drives the processor bus and checks reads against a shadow memory.
`timescale 1ns/1ns
`default_nettype none
`include "cache_cfg.svh"

module tb_cache import cache_pkg::*; ();

    localparam logic [31:0] SEED           = 32'h8858_a27d;
    localparam int          MEM_WORDS      = 1 << $bits(waddr_t);
    localparam int          TIMEOUT_CYCLES = 400;
    localparam int          RANDOM_OPS     = 400;
    localparam waddr_t      LINE_A         = 14'h0124;
    localparam waddr_t      LINE_B         = 14'h0144;
    localparam waddr_t      LINE_C         = 14'h0164;

    logic   clk;
    logic   rst_n;
    logic   re;
    logic   we;
    waddr_t addr;
    word_t  wdata;
    word_t  rdata;
    logic   ready;
    logic   xm_re;
    logic   xm_we;
    waddr_t xm_addr;
    word_t  xm_wdata;
    word_t  xm_rdata;
    logic   xm_ready;

    word_t       shadow [MEM_WORDS];
    logic [31:0] rng;
    word_t       expected_word;
    logic        in_flight;
    logic        in_flight_read;
    int          read_errors;
    int          check_errors;
    int          timeouts;
    int          xm_reads;
    int          xm_writes;

    cache_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .re       (re),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ready    (ready),
        .xm_re    (xm_re),
        .xm_we    (xm_we),
        .xm_addr  (xm_addr),
        .xm_wdata (xm_wdata),
        .xm_rdata (xm_rdata),
        .xm_ready (xm_ready)
    );

    ext_mem_model #(
        .SEED  (SEED),
        .DEPTH (MEM_WORDS)
    ) xmem (
        .clk      (clk),
        .rst_n    (rst_n),
        .xm_re    (xm_re),
        .xm_we    (xm_we),
        .xm_addr  (xm_addr),
        .xm_wdata (xm_wdata),
        .xm_rdata (xm_rdata),
        .xm_ready (xm_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        rng = lcg_step(rng);
        return rng;
    endfunction

    // Same contents as the external memory starts with.
    function automatic word_t initial_word(input int i);
        return lcg_step(SEED ^ 32'(i));
    endfunction

    // Shadow memory model of the whole system.
    function automatic word_t shadow_access(input logic is_write, input waddr_t a,
                                            input word_t d);
        if (is_write) begin
            shadow[a] = d;
        end
        return shadow[a];
    endfunction

    task automatic end_run();
        $display("Errors: %0d read mismatches, %0d check failures, %0d timeouts",
                 read_errors, check_errors, timeouts);
        if (read_errors + check_errors + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (!ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("Timeout at %0t: ready stayed low while waiting for %s", $time, what);
            timeouts++;
            end_run();
        end
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERR %0t %s: got %0d expected %0d", $time, name, got, exp);
            check_errors++;
        end
    endtask

    // One processor access from drive to completion.
    task automatic access(input logic is_write, input waddr_t a, input word_t d);
        @(negedge clk);
        wait_ready("the bus to accept a request");
        expected_word = shadow_access(is_write, a, d);
        re    = !is_write;
        we    = is_write;
        addr  = a;
        wdata = d;
        @(posedge clk);
        @(negedge clk);
        wait_ready("an access to complete");
        re = 1'b0;
        we = 1'b0;
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (xmem.mem[i] == shadow[i]) else begin
                $display("ERR %0t xmem.mem[%04h]: got %h expected %h",
                         $time, i, xmem.mem[i], shadow[i]);
                check_errors++;
            end
        end
    endtask

    // Words moved on the external bus.
    always @(posedge clk) begin
        if (rst_n && xm_ready) begin
            if (xm_re) begin
                xm_reads++;
            end
            if (xm_we) begin
                xm_writes++;
            end
        end
    end

    // Read data is checked at the edge that ends the access.
    always @(posedge clk) begin
        if (!rst_n) begin
            in_flight = 1'b0;
        end else begin
            if (in_flight && ready) begin
                in_flight = 1'b0;
                if (in_flight_read) begin
                    assert (rdata == expected_word) else begin
                        $display("ERR %0t rdata: got %h expected %h",
                                 $time, rdata, expected_word);
                        read_errors++;
                    end
                end
            end
            if (ready && (re || we)) begin
                in_flight      = 1'b1;
                in_flight_read = re;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        waddr_t      a;
        tag_t        flush_tag;
        int          base_rd;
        int          base_wr;
        rst_n          = 1'b0;
        re             = 1'b0;
        we             = 1'b0;
        addr           = '0;
        wdata          = '0;
        rng            = SEED;
        expected_word  = '0;
        in_flight      = 1'b0;
        in_flight_read = 1'b0;
        read_errors    = 0;
        check_errors   = 0;
        timeouts       = 0;
        xm_reads       = 0;
        xm_writes      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = initial_word(i);
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Tags are still being cleared right after reset.
        check_value("ready", int'(ready), 0);

        // Idle bus once the tag sweep is over.
        wait_ready("the tag clear");
        check_value("xm_re", int'(xm_re), 0);
        check_value("xm_we", int'(xm_we), 0);

        // Read miss and then hits on the rest of the line.
        base_rd = xm_reads;
        base_wr = xm_writes;
        for (int k = 0; k < 4; k++) begin
            access(1'b0, LINE_A + waddr_t'(k), '0);
        end
        check_value("xm read words", xm_reads - base_rd, 4);
        check_value("xm write words", xm_writes - base_wr, 0);

        // Write hit stays in the cache.
        base_rd = xm_reads;
        base_wr = xm_writes;
        access(1'b1, LINE_A + 14'd2, 32'ha5a5_0002);
        access(1'b0, LINE_A + 14'd2, '0);
        check_value("xm read words", xm_reads - base_rd, 0);
        check_value("xm write words", xm_writes - base_wr, 0);

        // Third tag at one index evicts the dirty line.
        base_rd = xm_reads;
        base_wr = xm_writes;
        access(1'b1, LINE_A, 32'h5a5a_0000);
        access(1'b0, LINE_B, '0);
        access(1'b0, LINE_C, '0);
        access(1'b0, LINE_A, '0);
        check_value("xm read words", xm_reads - base_rd, 12);
        check_value("xm write words", xm_writes - base_wr, 4);
        compare_memory();

        // Random mix over four tags and four sets.
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_random();
            a = {7'h30, r[25:24], 1'b0, r[27:26], r[29:28]};
            access(r[31], a, next_random());
        end

        // Two fresh tags per set push every dirty line out.
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int t = 0; t < 2; t++) begin
                flush_tag = (t == 0) ? 9'h1f0 : 9'h1f1;
                access(1'b0, {flush_tag, index_t'(s), 2'b00}, '0);
            end
        end
        compare_memory();

        @(posedge clk);
        @(negedge clk);
        end_run();
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cache_pkg.sv
sdp_ram.sv
tag_store.sv
line_engine.sv
cache_top.sv
ext_mem_model.sv
tb_cache.sv

//--- Makefile
BIN  := obj_dir/Vtb_cache
SRCS := $(filter-out +%,$(shell cat list.f)) cache_cfg.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): list.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_cache -Mdir obj_dir -f list.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "failure reported in sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
